//--- verification/tile_ctrl_vectors.txt
// op(0 rd, 1 wr, F end) addr wdata strb exp_rdata exp_err then outputs:
// cl_rst_n cl_clk_en mem_rst_n mem_clk_en spu_rst_n spu_clk_en
// exp_rdata is checked on reads and on error responses
0 00000000 00000000 0 00000000 0 0 0 0 0 0 0
0 00000004 00000000 0 00000000 0 0 0 0 0 0 0
0 00000008 00000000 0 00000000 0 0 0 0 0 0 0
0 0000000C 00000000 0 00000000 0 0 0 0 0 0 0
0 00000010 00000000 0 00000000 0 0 0 0 0 0 0
0 00000014 00000000 0 00000000 0 0 0 0 0 0 0
1 00000000 FFFFFFF5 F 00000000 0 5 0 0 0 0 0
0 00000000 00000000 0 00000005 0 5 0 0 0 0 0
1 00000004 0000000A 1 00000000 0 5 A 0 0 0 0
0 00000004 00000000 0 0000000A 0 5 A 0 0 0 0
1 00000008 00000003 F 00000000 0 5 A 3 0 0 0
0 00000008 00000000 0 00000003 0 5 A 3 0 0 0
1 0000000C 0000000C F 00000000 0 5 A 3 C 0 0
0 0000000C 00000000 0 0000000C 0 5 A 3 C 0 0
1 00000010 FFFFFFFF F 00000000 0 5 A 3 C 1 0
0 00000010 00000000 0 00000001 0 5 A 3 C 1 0
1 00000014 00000003 F 00000000 0 5 A 3 C 1 1
0 00000014 00000000 0 00000001 0 5 A 3 C 1 1
1 00000000 0000000F E 00000000 0 5 A 3 C 1 1
0 00000000 00000000 0 00000005 0 5 A 3 C 1 1
1 00000014 00000000 2 00000000 0 5 A 3 C 1 1
0 00000014 00000000 0 00000001 0 5 A 3 C 1 1
0 00000018 00000000 0 CA11AB1E 1 5 A 3 C 1 1
1 00000040 FFFFFFFF F CA11AB1E 1 5 A 3 C 1 1
0 00000FFC 00000000 0 CA11AB1E 1 5 A 3 C 1 1
1 00000FFC 00000000 F CA11AB1E 1 5 A 3 C 1 1
0 00000040 00000000 0 CA11AB1E 1 5 A 3 C 1 1
1 00000000 0000000F F 00000000 0 F A 3 C 1 1
1 00000004 0000000F F 00000000 0 F F 3 C 1 1
0 00000000 00000000 0 0000000F 0 F F 3 C 1 1
0 00000004 00000000 0 0000000F 0 F F 3 C 1 1
F 00000000 00000000 0 00000000 0 0 0 0 0 0 0

//--- tb.f
+incdir+include
hw/reg_bus_pkg.sv
hw/domain_ctrl_pkg.sv
hw/reg_apb_bridge.sv
hw/domain_ctrl_reg.sv
hw/soc_ctrl_regs.sv
hw/tile_ctrl_top.sv
verification/tile_ctrl_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tile_ctrl_tb
FILELIST  := tb.f
VFLAGS    := --binary --timing -j 0 --top-module $(TOP)
LINTFLAGS := --lint-only --timing --top-module $(TOP)
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/tile_ctrl_tb.sv
// Tile control-register path testbench
// Replays register accesses from the vector file and checks read data,
// errors, ready timing and the domain control outputs every cycle

`timescale 1ns/100ps
`default_nettype none

`include "tile_ctrl_settings.svh"

module tile_ctrl_tb;

  import reg_bus_pkg::*;

  localparam int rec_len     = 12;
  localparam int max_vectors = 64;
  localparam int ready_limit = 20;
  localparam int ready_delay = 2;

  logic                         clk_i;
  logic                         reset_i;
  reg_req_t                     reg_req_i;
  reg_rsp_t                     reg_rsp_o;
  logic [`TC_NUM_CLUSTERS-1:0]  cluster_rst_n_o;
  logic [`TC_NUM_CLUSTERS-1:0]  cluster_clk_en_o;
  logic [`TC_NUM_MEM_TILES-1:0] mem_tile_rst_n_o;
  logic [`TC_NUM_MEM_TILES-1:0] mem_tile_clk_en_o;
  logic                         spu_rst_n_o;
  logic                         spu_clk_en_o;

  logic [31:0] vec_mem [0:rec_len*max_vectors-1];
  logic [31:0] cur_out [0:5];
  logic [31:0] rand_state;
  int          errors;

  tile_ctrl_top tile_ctrl_top_inst (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .reg_req_i        (reg_req_i),
    .reg_rsp_o        (reg_rsp_o),
    .cluster_rst_n_o  (cluster_rst_n_o),
    .cluster_clk_en_o (cluster_clk_en_o),
    .mem_tile_rst_n_o (mem_tile_rst_n_o),
    .mem_tile_clk_en_o(mem_tile_clk_en_o),
    .spu_rst_n_o      (spu_rst_n_o),
    .spu_clk_en_o     (spu_clk_en_o)
  );

  always #20 clk_i = ~clk_i;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] next_rand(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic abort_run();
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
      abort_run();
    end
  endtask

  // Outputs against the state left by the last completed access
  task automatic verify_outputs();
    compare_value(32'(cluster_rst_n_o), cur_out[0], "cluster_rst_n_o");
    compare_value(32'(cluster_clk_en_o), cur_out[1], "cluster_clk_en_o");
    compare_value(32'(mem_tile_rst_n_o), cur_out[2], "mem_tile_rst_n_o");
    compare_value(32'(mem_tile_clk_en_o), cur_out[3], "mem_tile_clk_en_o");
    compare_value(32'(spu_rst_n_o), cur_out[4], "spu_rst_n_o");
    compare_value(32'(spu_clk_en_o), cur_out[5], "spu_clk_en_o");
  endtask

  task automatic watch_idle_cycle();
    compare_value(32'(reg_rsp_o.ready), 32'd0, "ready outside a response cycle");
    verify_outputs();
  endtask

  ////////////////////////////////////////
  // Stimulus and checking
  ////////////////////////////////////////

  initial begin : stimulus
    int          base;
    int          cycles;
    logic [1:0]  gap;
    logic [31:0] op;
    clk_i      = 1'b0;
    reset_i    = 1'b1;
    reg_req_i  = '0;
    errors     = 0;
    rand_state = 32'h8eb6_10a1;
    for (int i = 0; i < 6; i++) begin
      cur_out[i] = '0;
    end
    $readmemh("verification/tile_ctrl_vectors.txt", vec_mem);
    if ($isunknown(vec_mem[0])) begin
      $display("Vector file verification/tile_ctrl_vectors.txt is missing or empty");
      abort_run();
    end
    repeat (8) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    for (int v = 0; v < max_vectors; v++) begin
      base = v * rec_len;
      op   = vec_mem[base];
      // Op F ends the list
      if (op == 32'hF) begin
        break;
      end
      rand_state = next_rand(rand_state);
      gap        = rand_state[31:30];
      repeat (gap) begin
        @(negedge clk_i);
        watch_idle_cycle();
        @(posedge clk_i);
        #2;
      end
      reg_req_i.addr  = vec_mem[base+1];
      reg_req_i.write = vec_mem[base][0];
      reg_req_i.wdata = vec_mem[base+2];
      reg_req_i.wstrb = vec_mem[base+3][`TC_STRB_WIDTH-1:0];
      reg_req_i.valid = 1'b1;
      cycles = 0;
      @(negedge clk_i);
      while (!reg_rsp_o.ready) begin
        verify_outputs();
        cycles++;
        if (cycles > ready_limit) begin
          $display("Timed out after %0d cycles waiting for ready, address %h",
                   cycles, vec_mem[base+1]);
          abort_run();
        end
        @(negedge clk_i);
      end
      compare_value(cycles, ready_delay, "cycles from valid to ready");
      // A write shows on the outputs only after the ready cycle
      verify_outputs();
      compare_value(32'(reg_rsp_o.error), vec_mem[base+5], "response error");
      if (op == 32'h0 || vec_mem[base+5] != 32'h0) begin
        compare_value(reg_rsp_o.rdata, vec_mem[base+4], "response rdata");
      end
      for (int k = 0; k < 6; k++) begin
        cur_out[k] = vec_mem[base+6+k];
      end
      @(posedge clk_i);
      #2;
      reg_req_i = '0;
    end
    @(negedge clk_i);
    watch_idle_cycle();
    if (errors == 0) begin
      $display("No errors");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

`default_nettype wire

//--- hw/tile_ctrl_top.sv
// Tile control-register path
// Register requests pass through the APB bridge into the control
// registers, whose fields drive the domain reset and clock enables

`timescale 1ns/100ps
`default_nettype none

`include "tile_ctrl_settings.svh"

module tile_ctrl_top (
  input  wire logic                         clk_i,
  input  wire logic                         reset_i,
  input  wire reg_bus_pkg::reg_req_t        reg_req_i,
  output reg_bus_pkg::reg_rsp_t             reg_rsp_o,
  output logic [`TC_NUM_CLUSTERS-1:0]       cluster_rst_n_o,
  output logic [`TC_NUM_CLUSTERS-1:0]       cluster_clk_en_o,
  output logic [`TC_NUM_MEM_TILES-1:0]      mem_tile_rst_n_o,
  output logic [`TC_NUM_MEM_TILES-1:0]      mem_tile_clk_en_o,
  output logic                              spu_rst_n_o,
  output logic                              spu_clk_en_o
);

  import reg_bus_pkg::*;
  import domain_ctrl_pkg::*;

  apb_req_t       apb_req;
  apb_rsp_t       apb_rsp;
  cluster_ctrl_t  cluster;
  mem_tile_ctrl_t mem_tile;
  spu_ctrl_t      spu;

  reg_apb_bridge reg_apb_bridge_inst (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .reg_req_i(reg_req_i),
    .reg_rsp_o(reg_rsp_o),
    .apb_req_o(apb_req),
    .apb_rsp_i(apb_rsp)
  );

  soc_ctrl_regs soc_ctrl_regs_inst (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .apb_req_i (apb_req),
    .apb_rsp_o (apb_rsp),
    .cluster_o (cluster),
    .mem_tile_o(mem_tile),
    .spu_o     (spu)
  );

  // Domain control fan-out
  assign cluster_rst_n_o   = cluster.rst_n;
  assign cluster_clk_en_o  = cluster.clk_en;
  assign mem_tile_rst_n_o  = mem_tile.rst_n;
  assign mem_tile_clk_en_o = mem_tile.clk_en;
  assign spu_rst_n_o       = spu.rst_n;
  assign spu_clk_en_o      = spu.clk_en;

endmodule

`default_nettype wire

//--- hw/soc_ctrl_regs.sv
// Tile control registers
// APB slave with the reset and clock-enable registers of the clusters,
// memory tiles and signal-processing unit; unmapped offsets answer
// with an error and a fixed pattern

`timescale 1ns/100ps
`default_nettype none

`include "tile_ctrl_settings.svh"

module soc_ctrl_regs (
  input  wire logic                        clk_i,
  input  wire logic                        reset_i,
  input  wire reg_bus_pkg::apb_req_t       apb_req_i,
  output reg_bus_pkg::apb_rsp_t            apb_rsp_o,
  output domain_ctrl_pkg::cluster_ctrl_t   cluster_o,
  output domain_ctrl_pkg::mem_tile_ctrl_t  mem_tile_o,
  output domain_ctrl_pkg::spu_ctrl_t       spu_o
);

  import domain_ctrl_pkg::*;

  logic                      access;
  logic                      wr_access;
  logic                      mapped;
  logic [`TC_DATA_WIDTH-1:0] rdata;

  logic cluster_rst_hit;
  logic cluster_clk_en_hit;
  logic mem_rst_hit;
  logic mem_clk_en_hit;
  logic spu_rst_hit;
  logic spu_clk_en_hit;

  ////////////////////////////////////////
  // Address decode and read data
  ////////////////////////////////////////

  assign access    = apb_req_i.psel && apb_req_i.penable;
  assign wr_access = access && apb_req_i.pwrite;

  always_comb begin
    cluster_rst_hit    = 1'b0;
    cluster_clk_en_hit = 1'b0;
    mem_rst_hit        = 1'b0;
    mem_clk_en_hit     = 1'b0;
    spu_rst_hit        = 1'b0;
    spu_clk_en_hit     = 1'b0;
    mapped             = 1'b1;
    rdata              = '0;
    case (apb_req_i.paddr)
      `TC_OFS_CLUSTER_RST: begin
        cluster_rst_hit                  = 1'b1;
        rdata[`TC_NUM_CLUSTERS-1:0]      = cluster_o.rst_n;
      end
      `TC_OFS_CLUSTER_CLK_EN: begin
        cluster_clk_en_hit               = 1'b1;
        rdata[`TC_NUM_CLUSTERS-1:0]      = cluster_o.clk_en;
      end
      `TC_OFS_MEM_RST: begin
        mem_rst_hit                      = 1'b1;
        rdata[`TC_NUM_MEM_TILES-1:0]     = mem_tile_o.rst_n;
      end
      `TC_OFS_MEM_CLK_EN: begin
        mem_clk_en_hit                   = 1'b1;
        rdata[`TC_NUM_MEM_TILES-1:0]     = mem_tile_o.clk_en;
      end
      `TC_OFS_SPU_RST: begin
        spu_rst_hit = 1'b1;
        rdata[0]    = spu_o.rst_n;
      end
      `TC_OFS_SPU_CLK_EN: begin
        spu_clk_en_hit = 1'b1;
        rdata[0]       = spu_o.clk_en;
      end
      default: begin
        // Error slave behaviour
        mapped = 1'b0;
        rdata  = `TC_ERR_DATA;
      end
    endcase
  end

  assign apb_rsp_o.prdata  = rdata;
  assign apb_rsp_o.pslverr = access && !mapped;

  ////////////////////////////////////////
  // Domain registers
  ////////////////////////////////////////

  domain_ctrl_reg #(
    .ctrl_t(cluster_ctrl_t)
  ) cluster_reg_inst (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .rst_we_i   (wr_access && cluster_rst_hit),
    .clk_en_we_i(wr_access && cluster_clk_en_hit),
    .wdata_i    (apb_req_i.pwdata),
    .wstrb_i    (apb_req_i.pstrb),
    .ctrl_o     (cluster_o)
  );

  domain_ctrl_reg #(
    .ctrl_t(mem_tile_ctrl_t)
  ) mem_tile_reg_inst (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .rst_we_i   (wr_access && mem_rst_hit),
    .clk_en_we_i(wr_access && mem_clk_en_hit),
    .wdata_i    (apb_req_i.pwdata),
    .wstrb_i    (apb_req_i.pstrb),
    .ctrl_o     (mem_tile_o)
  );

  domain_ctrl_reg #(
    .ctrl_t(spu_ctrl_t)
  ) spu_reg_inst (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .rst_we_i   (wr_access && spu_rst_hit),
    .clk_en_we_i(wr_access && spu_clk_en_hit),
    .wdata_i    (apb_req_i.pwdata),
    .wstrb_i    (apb_req_i.pstrb),
    .ctrl_o     (spu_o)
  );

endmodule

`default_nettype wire

//--- hw/domain_ctrl_reg.sv
// Domain control register pair
// Holds the reset and clock-enable fields of one domain group, field
// width taken from the control type, written bytewise under strobes

`timescale 1ns/100ps
`default_nettype none

`include "tile_ctrl_settings.svh"

module domain_ctrl_reg #(
  parameter type ctrl_t = domain_ctrl_pkg::spu_ctrl_t
) (
  input  wire logic                      clk_i,
  input  wire logic                      reset_i,
  input  wire logic                      rst_we_i,
  input  wire logic                      clk_en_we_i,
  input  wire logic [`TC_DATA_WIDTH-1:0] wdata_i,
  input  wire logic [`TC_STRB_WIDTH-1:0] wstrb_i,
  output ctrl_t                          ctrl_o
);

  // Both fields share one width
  localparam int unsigned field_w = $bits(ctrl_t) / 2;

  ctrl_t              ctrl_q;
  logic [field_w-1:0] rst_n_d;
  logic [field_w-1:0] clk_en_d;

  always_comb begin
    rst_n_d  = ctrl_q.rst_n;
    clk_en_d = ctrl_q.clk_en;
    for (int i = 0; i < field_w; i++) begin
      // Bit i lives in byte i/8
      if (wstrb_i[i/8]) begin
        if (rst_we_i) begin
          rst_n_d[i] = wdata_i[i];
        end
        if (clk_en_we_i) begin
          clk_en_d[i] = wdata_i[i];
        end
      end
    end
  end

  // Cleared state keeps the domains in reset with clocks gated
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ctrl_q <= '0;
    end else begin
      ctrl_q.rst_n  <= rst_n_d;
      ctrl_q.clk_en <= clk_en_d;
    end
  end

  assign ctrl_o = ctrl_q;

endmodule

`default_nettype wire

//--- hw/reg_apb_bridge.sv
// Register-interface to APB bridge
// Turns one register request into an APB setup and access phase and
// returns the slave's answer as a single-cycle ready pulse

`timescale 1ns/100ps
`default_nettype none

`include "tile_ctrl_settings.svh"

module reg_apb_bridge (
  input  wire logic                  clk_i,
  input  wire logic                  reset_i,
  input  wire reg_bus_pkg::reg_req_t reg_req_i,
  output reg_bus_pkg::reg_rsp_t      reg_rsp_o,
  output reg_bus_pkg::apb_req_t      apb_req_o,
  input  wire reg_bus_pkg::apb_rsp_t apb_rsp_i
);

  typedef enum logic [1:0] {
    st_idle,
    st_setup,
    st_access
  } state_e;

  state_e state_q;
  state_e state_d;

  logic                      accept;
  logic [`TC_ADDR_WIDTH-1:0] paddr_q;
  logic                      pwrite_q;
  logic [`TC_DATA_WIDTH-1:0] pwdata_q;
  logic [`TC_STRB_WIDTH-1:0] pstrb_q;

  ////////////////////////////////////////
  // State machine
  ////////////////////////////////////////

  // New request is taken only from idle, otherwise it waits
  assign accept = (state_q == st_idle) && reg_req_i.valid;

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (accept) begin
          state_d = st_setup;
        end
      end
      st_setup: begin
        state_d = st_access;
      end
      st_access: begin
        // Slave always completes in the access cycle
        state_d = st_idle;
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////
  // Request capture
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (accept) begin
      paddr_q  <= reg_req_i.addr;
      pwrite_q <= reg_req_i.write;
      pwdata_q <= reg_req_i.wdata;
      pstrb_q  <= reg_req_i.wstrb;
    end
  end

  ////////////////////////////////////////
  // APB and response outputs
  ////////////////////////////////////////

  assign apb_req_o.paddr   = paddr_q;
  assign apb_req_o.psel    = (state_q != st_idle);
  assign apb_req_o.penable = (state_q == st_access);
  assign apb_req_o.pwrite  = pwrite_q;
  assign apb_req_o.pwdata  = pwdata_q;
  assign apb_req_o.pstrb   = pstrb_q;

  // Slave answer is passed straight through with the ready pulse
  assign reg_rsp_o.rdata = apb_rsp_i.prdata;
  assign reg_rsp_o.error = apb_rsp_i.pslverr;
  assign reg_rsp_o.ready = (state_q == st_access);

endmodule

`default_nettype wire

//--- hw/domain_ctrl_pkg.sv
// Domain control types
// Reset and clock-enable fields for the compute clusters, the memory
// tiles and the signal-processing unit

`default_nettype none

`include "tile_ctrl_settings.svh"

package domain_ctrl_pkg;

  // rst_n is active low, so a cleared field holds the domain in reset

  typedef struct packed {
    logic [`TC_NUM_CLUSTERS-1:0] rst_n;
    logic [`TC_NUM_CLUSTERS-1:0] clk_en;
  } cluster_ctrl_t;

  typedef struct packed {
    logic [`TC_NUM_MEM_TILES-1:0] rst_n;
    logic [`TC_NUM_MEM_TILES-1:0] clk_en;
  } mem_tile_ctrl_t;

  // Single signal-processing unit
  typedef struct packed {
    logic rst_n;
    logic clk_en;
  } spu_ctrl_t;

endpackage

`default_nettype wire

//--- hw/reg_bus_pkg.sv
// Register bus types
// Request and response structs for the register interface and the APB
// link between the bridge and the control-register block

`default_nettype none

`include "tile_ctrl_settings.svh"

package reg_bus_pkg;

  ////////////////////////////////////////
  // Register interface
  ////////////////////////////////////////

  typedef struct packed {
    logic [`TC_ADDR_WIDTH-1:0] addr;
    logic                      write;
    logic [`TC_DATA_WIDTH-1:0] wdata;
    logic [`TC_STRB_WIDTH-1:0] wstrb;
    logic                      valid;
  } reg_req_t;

  // Ready is a one-cycle pulse carrying rdata and error
  typedef struct packed {
    logic [`TC_DATA_WIDTH-1:0] rdata;
    logic                      error;
    logic                      ready;
  } reg_rsp_t;

  ////////////////////////////////////////
  // APB
  ////////////////////////////////////////

  typedef struct packed {
    logic [`TC_ADDR_WIDTH-1:0] paddr;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [`TC_DATA_WIDTH-1:0] pwdata;
    logic [`TC_STRB_WIDTH-1:0] pstrb;
  } apb_req_t;

  // No pready since the slave never inserts wait states
  typedef struct packed {
    logic [`TC_DATA_WIDTH-1:0] prdata;
    logic                      pslverr;
  } apb_rsp_t;

endpackage

`default_nettype wire

//--- include/tile_ctrl_settings.svh
// Tile control settings
// Bus widths, domain counts, register map and the error read pattern
// shared by the packages and the control-register RTL

`ifndef TILE_CTRL_SETTINGS_SVH
`define TILE_CTRL_SETTINGS_SVH

// Register and APB bus widths
`define TC_ADDR_WIDTH 32
`define TC_DATA_WIDTH 32
`define TC_STRB_WIDTH 4

// Neighbour domain counts
`define TC_NUM_CLUSTERS 4
`define TC_NUM_MEM_TILES 4

// Register byte offsets
`define TC_OFS_CLUSTER_RST    32'h0000_0000
`define TC_OFS_CLUSTER_CLK_EN 32'h0000_0004
`define TC_OFS_MEM_RST        32'h0000_0008
`define TC_OFS_MEM_CLK_EN     32'h0000_000C
`define TC_OFS_SPU_RST        32'h0000_0010
`define TC_OFS_SPU_CLK_EN     32'h0000_0014

// Read data for an unmapped address
`define TC_ERR_DATA 32'hCA11AB1E

`endif
